// File: run_sim.sh
#!/usr/bin/env bash
# build and run the video controller testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module video_tb -o Vvideo_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vvideo_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "testbench reported failure"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi
exit 0

// File: source/line_fetch.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module line_fetch (
   input  logic                  pxclk,
   input  logic                  rst,
   input  logic                  line_req,
   input  logic [8:0]            next_line,
   input  video_pkg::vram_addr_t sar,
   input  logic [1:0]            row_shift,
   input  logic                  fetch_gnt,
   input  logic                  credit_return,
   output logic                  fetch_req,
   output video_pkg::vram_addr_t fetch_addr
);

   localparam int CRED_W = $clog2(`PIX_FIFO_DEPTH + 1);

   logic [CRED_W-1:0]     credits;
   logic [6:0]            words_left;
   logic [8:0]            mem_line;
   video_pkg::vram_addr_t line_base;

   // row repeat, 2**row_shift scanlines per memory line
   always_comb begin
      mem_line  = next_line >> row_shift;
      line_base = sar + video_pkg::vram_addr_t'(mem_line * `H_VISIBLE);
   end

   // only ask while the fifo has a guaranteed slot
   assign fetch_req = (words_left != 7'd0) && (credits != '0);

   //////////////////////////////////////////////////
   // burst address and credit counter
   //////////////////////////////////////////////////

   always_ff @(posedge pxclk) begin
      if (rst) begin
         credits    <= CRED_W'(`PIX_FIFO_DEPTH);
         words_left <= '0;
         fetch_addr <= '0;
      end else begin
         if (line_req) begin
            fetch_addr <= line_base;
            words_left <= 7'(`H_VISIBLE);
         end else if (fetch_gnt) begin
            fetch_addr <= fetch_addr + 1'b1;
            words_left <= words_left - 1'b1;
         end
         // grant takes one, pop gives one back
         credits <= credits - CRED_W'(fetch_gnt) + CRED_W'(credit_return);
      end
   end

   a_credit_bound: assert property (@(posedge pxclk) disable iff (rst)
      credits <= CRED_W'(`PIX_FIFO_DEPTH))
      else $error("credit count above fifo depth");

endmodule

// File: source/pixel_out.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module pixel_out (
   input  logic                 pxclk,
   input  logic                 rst,
   input  logic                 fetch_valid,
   input  video_pkg::pix_word_t fetch_data,
   input  logic [2:0]           px,
   input  logic                 visible,
   input  logic                 hsync_n,
   input  logic                 vsync_n,
   input  video_pkg::color_t    palette [4],
   output logic                 credit_return,
   output logic [2:0]           r,
   output logic [2:0]           g,
   output logic [2:0]           b,
   output logic                 hs,
   output logic                 vs
);

   localparam int PTR_W = $clog2(`PIX_FIFO_DEPTH);

   video_pkg::pix_word_t fifo [`PIX_FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [PTR_W:0]       count;
   logic                 empty;
   logic                 full;
   logic                 col_start;
   logic                 pop;
   logic                 sync_seen;
   video_pkg::pix_word_t shreg;
   logic [1:0]           idx;
   video_pkg::color_t    color;

   assign empty     = (count == '0);
   assign full      = (count == (PTR_W+1)'(`PIX_FIFO_DEPTH));
   assign col_start = visible && (px == 3'd0);
   // nothing to pop in the first frame after reset
   assign pop       = col_start && !empty;

   // first pixel comes straight from the fifo head
   assign idx   = pop ? fifo[rd_ptr][15:14] : shreg[15:14];
   assign color = palette[idx];

   //////////////////////////////////////////////////
   // word fifo
   //////////////////////////////////////////////////

   always_ff @(posedge pxclk) begin
      if (rst) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
         sync_seen     <= 1'b0;
      end else begin
         if (fetch_valid) wr_ptr <= (wr_ptr == PTR_W'(`PIX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop) rd_ptr <= (rd_ptr == PTR_W'(`PIX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count         <= count + (PTR_W+1)'(fetch_valid) - (PTR_W+1)'(pop);
         credit_return <= pop;
         if (!vsync_n) sync_seen <= 1'b1;
      end
   end

   always_ff @(posedge pxclk) begin
      if (fetch_valid) fifo[wr_ptr] <= fetch_data;
      // load on pop, else shift the next index up
      shreg <= pop ? {fifo[rd_ptr][13:0], 2'b00} : {shreg[13:0], 2'b00};
   end

   //////////////////////////////////////////////////
   // registered video outputs
   //////////////////////////////////////////////////

   always_ff @(posedge pxclk) begin
      if (rst) begin
         hs <= 1'b1;
         vs <= 1'b1;
         r  <= '0;
         g  <= '0;
         b  <= '0;
      end else begin
         hs <= hsync_n;
         vs <= vsync_n;
         r  <= visible ? color.r : 3'd0;
         g  <= visible ? color.g : 3'd0;
         b  <= visible ? color.b : 3'd0;
      end
   end

   a_no_overflow: assert property (@(posedge pxclk) disable iff (rst)
      fetch_valid |-> !full)
      else $error("push into full pixel fifo");

   a_no_underflow: assert property (@(posedge pxclk) disable iff (rst)
      col_start && sync_seen |-> !empty)
      else $error("pixel fifo empty in visible video");

endmodule

// File: source/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

//////////////////////////////////////////////////
// horizontal timing, in character columns
//////////////////////////////////////////////////

`define H_VISIBLE      80
`define H_SYNC_START   80
`define H_SYNC_END     83
`define H_TOTAL        100

//////////////////////////////////////////////////
// vertical timing, in scanlines
//////////////////////////////////////////////////

`define V_VISIBLE      400
`define V_SYNC_START   400
`define V_SYNC_END     409
`define V_TOTAL        449

// pixels per column word
`define COL_PIXELS     8

// words buffered between fetcher and shifter
`define PIX_FIFO_DEPTH 4

`endif

// File: source/video_pkg.sv
package video_pkg;

   // cpu i/o register map
   typedef enum logic [2:0] {
      SAR  = 3'd0,
      MR   = 3'd1,
      VAR  = 3'd2,
      VDR  = 3'd3,
      STAT = 3'd4,
      PAL  = 3'd5
   } reg_addr_e;

   // one column of 8 pixels, 2 bits each, first pixel in 15:14
   typedef logic [15:0] pix_word_t;

   typedef logic [15:0] vram_addr_t;

   // palette entry, red in the top bits
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } color_t;

endpackage

// File: source/video_regs.sv
`timescale 1ns/1ns

module video_regs (
   input  logic                  pxclk,
   input  logic                  rst,
   input  logic                  io_sel,
   input  logic                  io_wr,
   input  logic                  io_rd,
   input  video_pkg::reg_addr_e  io_addr,
   input  logic [15:0]           io_wdata,
   input  logic                  vblank,
   input  logic                  cpu_gnt,
   input  video_pkg::pix_word_t  cpu_rdata,
   output logic [15:0]           io_rdata,
   output video_pkg::vram_addr_t sar,
   output logic [1:0]            row_shift,
   output logic                  cpu_req,
   output logic                  cpu_we,
   output video_pkg::vram_addr_t cpu_addr,
   output video_pkg::pix_word_t  cpu_wdata,
   output video_pkg::color_t     palette [4]
);

   logic [15:0]           mr_q;
   video_pkg::vram_addr_t var_q;
   video_pkg::pix_word_t  vdr_q;
   logic                  rd_pending;
   logic                  busy;
   logic                  wr_stb;
   logic                  rd_stb;

   assign wr_stb    = io_sel && io_wr;
   assign rd_stb    = io_sel && io_rd;
   // a cpu vram access is in flight until its read data has landed
   assign busy      = cpu_req || rd_pending;
   assign row_shift = mr_q[1:0];

   //////////////////////////////////////////////////
   // control registers and vram request
   //////////////////////////////////////////////////

   always_ff @(posedge pxclk) begin
      if (rst) begin
         sar        <= '0;
         mr_q       <= '0;
         var_q      <= '0;
         cpu_req    <= 1'b0;
         rd_pending <= 1'b0;
         for (int i = 0; i < 4; i++) palette[i] <= '0;
      end else begin
         rd_pending <= cpu_gnt && !cpu_we;
         if (cpu_gnt) cpu_req <= 1'b0;
         if (wr_stb) begin
            case (io_addr)
               video_pkg::SAR: sar  <= io_wdata;
               video_pkg::MR:  mr_q <= io_wdata;
               video_pkg::VAR: begin
                  // new address, prefetch into the latch
                  var_q   <= io_wdata;
                  cpu_req <= 1'b1;
               end
               video_pkg::VDR: begin
                  var_q   <= var_q + 1'b1;
                  cpu_req <= 1'b1;
               end
               video_pkg::PAL: palette[io_wdata[10:9]] <= video_pkg::color_t'(io_wdata[8:0]);
               default: ;
            endcase
         end else if (rd_stb && io_addr == video_pkg::VDR) begin
            // step on and prefetch the next word
            var_q   <= var_q + 1'b1;
            cpu_req <= 1'b1;
         end
      end
   end

   // request payload, latched with the request
   always_ff @(posedge pxclk) begin
      if (wr_stb && io_addr == video_pkg::VAR) begin
         cpu_addr <= io_wdata;
         cpu_we   <= 1'b0;
      end else if (wr_stb && io_addr == video_pkg::VDR) begin
         cpu_addr  <= var_q;
         cpu_we    <= 1'b1;
         cpu_wdata <= io_wdata;
      end else if (rd_stb && io_addr == video_pkg::VDR) begin
         cpu_addr <= var_q + 1'b1;
         cpu_we   <= 1'b0;
      end
      if (rd_pending) vdr_q <= cpu_rdata;
   end

   // read mux, data valid the cycle after io_rd
   always_ff @(posedge pxclk) begin
      if (rd_stb) begin
         case (io_addr)
            video_pkg::SAR:  io_rdata <= sar;
            video_pkg::MR:   io_rdata <= mr_q;
            video_pkg::VAR:  io_rdata <= var_q;
            video_pkg::VDR:  io_rdata <= vdr_q;
            video_pkg::STAT: io_rdata <= {14'd0, busy, vblank};
            default:         io_rdata <= '0;
         endcase
      end
   end

   // software must see busy clear before touching var or vdr again
   a_no_access_while_busy: assert property (@(posedge pxclk) disable iff (rst)
      (wr_stb && io_addr inside {video_pkg::VAR, video_pkg::VDR}) ||
      (rd_stb && io_addr == video_pkg::VDR) |-> !busy)
      else $error("vram access issued while busy");

endmodule

// File: source/video_timing.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_timing (
   input  logic       pxclk,
   input  logic       rst,
   output logic [2:0] px,
   output logic [6:0] col,
   output logic [8:0] line,
   output logic       visible,
   output logic       hsync_n,
   output logic       vsync_n,
   output logic       vblank,
   output logic       line_req,
   output logic [8:0] next_line
);

   logic px_last;
   logic col_last;
   logic line_last;

   assign px_last   = (px == 3'(`COL_PIXELS - 1));
   assign col_last  = (col == 7'(`H_TOTAL - 1));
   assign line_last = (line == 9'(`V_TOTAL - 1));

   //////////////////////////////////////////////////
   // pixel, column and line counters
   //////////////////////////////////////////////////

   always_ff @(posedge pxclk) begin
      if (rst) begin
         px   <= '0;
         col  <= '0;
         line <= '0;
      end else begin
         px <= px_last ? 3'd0 : px + 1'b1;
         if (px_last) begin
            col <= col_last ? 7'd0 : col + 1'b1;
            // line steps at the end of the last column
            if (col_last) line <= line_last ? 9'd0 : line + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // sync and blanking decode
   //////////////////////////////////////////////////

   // sync pulses are active low
   assign hsync_n = !(col >= 7'(`H_SYNC_START) && col < 7'(`H_SYNC_END));
   assign vsync_n = !(line >= 9'(`V_SYNC_START) && line < 9'(`V_SYNC_END));
   assign vblank  = (line >= 9'(`V_VISIBLE));
   assign visible = (col < 7'(`H_VISIBLE)) && !vblank;

   // look ahead one line for the fetcher
   assign next_line = line_last ? 9'd0 : line + 1'b1;

   // fires once per line as horizontal blanking starts
   assign line_req = (px == 3'd0) && (col == 7'(`H_SYNC_START)) &&
                     (next_line < 9'(`V_VISIBLE));

endmodule

// File: source/video_top.sv
`timescale 1ns/1ns

module video_top (
   input  logic                 pxclk,
   input  logic                 rst,
   input  logic                 io_sel,
   input  logic                 io_wr,
   input  logic                 io_rd,
   input  video_pkg::reg_addr_e io_addr,
   input  logic [15:0]          io_wdata,
   output logic [15:0]          io_rdata,
   output logic [2:0]           r,
   output logic [2:0]           g,
   output logic [2:0]           b,
   output logic                 hs,
   output logic                 vs
);

   // cpu side
   video_pkg::vram_addr_t sar;
   logic [1:0]            row_shift;
   logic                  cpu_req;
   logic                  cpu_we;
   logic                  cpu_gnt;
   video_pkg::vram_addr_t cpu_addr;
   video_pkg::pix_word_t  cpu_wdata;
   video_pkg::pix_word_t  cpu_rdata;
   video_pkg::color_t     palette [4];

   // timing
   logic [2:0] px;
   logic [6:0] col;
   logic [8:0] line;
   logic       visible;
   logic       hsync_n;
   logic       vsync_n;
   logic       vblank;
   logic       line_req;
   logic [8:0] next_line;

   // video fetch path
   logic                  fetch_req;
   logic                  fetch_gnt;
   logic                  fetch_valid;
   logic                  credit_return;
   video_pkg::vram_addr_t fetch_addr;
   video_pkg::pix_word_t  fetch_data;

   video_regs u_regs (
      .pxclk, .rst, .io_sel, .io_wr, .io_rd, .io_addr, .io_wdata, .vblank,
      .cpu_gnt, .cpu_rdata, .io_rdata, .sar, .row_shift, .cpu_req, .cpu_we,
      .cpu_addr, .cpu_wdata, .palette
   );

   video_timing u_timing (
      .pxclk, .rst, .px, .col, .line, .visible, .hsync_n, .vsync_n, .vblank,
      .line_req, .next_line
   );

   line_fetch u_fetch (
      .pxclk, .rst, .line_req, .next_line, .sar, .row_shift, .fetch_gnt,
      .credit_return, .fetch_req, .fetch_addr
   );

   vram u_vram (
      .pxclk, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .fetch_req, .fetch_addr,
      .cpu_gnt, .cpu_rdata, .fetch_gnt, .fetch_valid, .fetch_data
   );

   pixel_out u_pix (
      .pxclk, .rst, .fetch_valid, .fetch_data, .px, .visible, .hsync_n,
      .vsync_n, .palette, .credit_return, .r, .g, .b, .hs, .vs
   );

endmodule

// File: source/vram.sv
`timescale 1ns/1ns

module vram (
   input  logic                  pxclk,
   input  logic                  cpu_req,
   input  logic                  cpu_we,
   input  video_pkg::vram_addr_t cpu_addr,
   input  video_pkg::pix_word_t  cpu_wdata,
   input  logic                  fetch_req,
   input  video_pkg::vram_addr_t fetch_addr,
   output logic                  cpu_gnt,
   output video_pkg::pix_word_t  cpu_rdata,
   output logic                  fetch_gnt,
   output logic                  fetch_valid,
   output video_pkg::pix_word_t  fetch_data
);

   video_pkg::pix_word_t  mem [65536];
   video_pkg::pix_word_t  rd_q;
   video_pkg::vram_addr_t acc_addr;

   //////////////////////////////////////////////////
   // fixed priority, video fetch wins
   //////////////////////////////////////////////////

   assign fetch_gnt = fetch_req;
   assign cpu_gnt   = cpu_req && !fetch_req;
   assign acc_addr  = fetch_req ? fetch_addr : cpu_addr;

   // single access per cycle, read data one cycle after grant
   always_ff @(posedge pxclk) begin
      if (cpu_gnt && cpu_we) mem[cpu_addr] <= cpu_wdata;
      rd_q        <= mem[acc_addr];
      fetch_valid <= fetch_gnt;
   end

   // both ports see the shared read register
   assign cpu_rdata  = rd_q;
   assign fetch_data = rd_q;

endmodule

// File: src.f
+incdir+source
source/video_pkg.sv
source/video_regs.sv
source/video_timing.sv
source/line_fetch.sv
source/vram.sv
source/pixel_out.sv
source/video_top.sv
tb/video_tb.sv

// File: tb/video_tb.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_tb;

   localparam int LINE_CYCLES    = `H_TOTAL * `COL_PIXELS;
   localparam int FRAME_CYCLES   = LINE_CYCLES * `V_TOTAL;
   localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 10000;

   logic                 pxclk;
   logic                 rst;
   logic                 io_sel;
   logic                 io_wr;
   logic                 io_rd;
   video_pkg::reg_addr_e io_addr;
   logic [15:0]          io_wdata;
   logic [15:0]          io_rdata;
   logic [2:0]           r;
   logic [2:0]           g;
   logic [2:0]           b;
   logic                 hs;
   logic                 vs;

   // expected palette and two memory lines of pixel words
   logic [8:0]           pal [4];
   video_pkg::pix_word_t pattern [2][`H_VISIBLE];

   video_top DUT (
      .pxclk, .rst, .io_sel, .io_wr, .io_rd, .io_addr, .io_wdata,
      .io_rdata, .r, .g, .b, .hs, .vs
   );

   initial pxclk = 1'b0;
   always #5 pxclk = ~pxclk;

   // four frames plus setup slack
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge pxclk);
      $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////
   // check and cpu bus helpers
   //////////////////////////////////////////////////

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1, "stopping on first error");
      end
   endtask

   // all bus tasks start and end on a falling edge
   task automatic io_write(input video_pkg::reg_addr_e addr, input logic [15:0] data);
      io_sel   = 1'b1;
      io_wr    = 1'b1;
      io_addr  = addr;
      io_wdata = data;
      @(negedge pxclk);
      io_sel = 1'b0;
      io_wr  = 1'b0;
   endtask

   // read data registered at the rising edge in between
   task automatic io_read(input video_pkg::reg_addr_e addr, output logic [15:0] data);
      io_sel  = 1'b1;
      io_rd   = 1'b1;
      io_addr = addr;
      @(negedge pxclk);
      io_sel = 1'b0;
      io_rd  = 1'b0;
      data   = io_rdata;
   endtask

   // stat bit1 is busy
   task automatic wait_not_busy();
      logic [15:0] stat;
      do begin
         io_read(video_pkg::STAT, stat);
      end while (stat[1]);
   endtask

   // counts falling edges until hs or vs reaches the level
   task automatic count_until(input bit sel_vs, input logic level, output int cycles);
      cycles = 0;
      while ((sel_vs ? vs : hs) !== level) begin
         @(negedge pxclk);
         cycles++;
      end
   endtask

   task automatic load_words(input video_pkg::vram_addr_t base, input int m);
      io_write(video_pkg::VAR, base);
      wait_not_busy();
      for (int i = 0; i < `H_VISIBLE; i++) begin
         pattern[m][i] = 16'($urandom);
         io_write(video_pkg::VDR, pattern[m][i]);
         wait_not_busy();
      end
   endtask

   // entry index in bits 10:9 and color in 8:0
   task automatic load_palette();
      for (int i = 0; i < 4; i++) begin
         pal[i] = 9'($urandom);
         io_write(video_pkg::PAL, {5'd0, 2'(i), pal[i]});
      end
   endtask

   // lines 409..448 lie between vs rising and line 0; outputs and vs share the same latency
   task automatic wait_first_pixel();
      int n;
      count_until(1'b1, 1'b0, n);
      count_until(1'b1, 1'b1, n);
      repeat ((`V_TOTAL - `V_SYNC_END) * LINE_CYCLES) @(negedge pxclk);
   endtask

   // one scanline of output against memory line m with black blanking
   task automatic check_scanline(input int m, input string name);
      int         col;
      int         p;
      logic [1:0] idx;
      logic [8:0] exp_c;
      for (int i = 0; i < LINE_CYCLES; i++) begin
         col   = i / `COL_PIXELS;
         p     = i % `COL_PIXELS;
         exp_c = 9'd0;
         if (col < `H_VISIBLE) begin
            idx   = pattern[m][col][15 - 2 * p -: 2];
            exp_c = pal[idx];
         end
         check(name, 32'({r, g, b}), 32'(exp_c));
         @(negedge pxclk);
      end
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic test_reg_readback();
      logic [15:0] v;
      logic [15:0] d;
      v = 16'($urandom);
      io_write(video_pkg::SAR, v);
      io_read(video_pkg::SAR, d);
      check("sar", 32'(d), 32'(v));
      v = 16'($urandom % 4);
      io_write(video_pkg::MR, v);
      io_read(video_pkg::MR, d);
      check("mr", 32'(d), 32'(v));
   endtask

   // runs with line fetches active so cpu grants get delayed
   task automatic test_vram_access();
      video_pkg::vram_addr_t base;
      video_pkg::pix_word_t  words [16];
      logic [15:0]           d;
      int                    n;
      base = 16'($urandom);
      for (int i = 0; i < 16; i++) words[i] = 16'($urandom);
      // hs falls as the fetcher starts its burst for the next line
      count_until(1'b0, 1'b1, n);
      count_until(1'b0, 1'b0, n);
      io_write(video_pkg::VAR, base);
      wait_not_busy();
      for (int i = 0; i < 16; i++) begin
         io_write(video_pkg::VDR, words[i]);
         wait_not_busy();
      end
      io_read(video_pkg::VAR, d);
      check("var", 32'(d), 32'(16'(base + 16'd16)));
      io_write(video_pkg::VAR, base);
      wait_not_busy();
      for (int i = 0; i < 16; i++) begin
         io_read(video_pkg::VDR, d);
         check("vdr", 32'(d), 32'(words[i]));
         wait_not_busy();
      end
   endtask

   task automatic test_sync_timing();
      int          n;
      int          low_t;
      int          high_t;
      logic [15:0] stat;
      // still in the first visible lines of the frame
      count_until(1'b0, 1'b1, n);
      count_until(1'b0, 1'b0, n);
      io_read(video_pkg::STAT, stat);
      check("stat vblank", 32'(stat[0]), 32'(0));
      // align on a falling hs edge
      count_until(1'b0, 1'b1, n);
      count_until(1'b0, 1'b0, n);
      count_until(1'b0, 1'b1, low_t);
      count_until(1'b0, 1'b0, high_t);
      check("hs low time", low_t, (`H_SYNC_END - `H_SYNC_START) * `COL_PIXELS);
      check("hs period", low_t + high_t, LINE_CYCLES);
      count_until(1'b1, 1'b1, n);
      count_until(1'b1, 1'b0, n);
      count_until(1'b1, 1'b1, low_t);
      count_until(1'b1, 1'b0, high_t);
      check("vs low time", low_t, (`V_SYNC_END - `V_SYNC_START) * LINE_CYCLES);
      check("vs period", low_t + high_t, FRAME_CYCLES);
      // vs just fell so the frame is in vertical blank
      io_read(video_pkg::STAT, stat);
      check("stat vblank", 32'(stat[0]), 32'(1));
   endtask

   task automatic test_pixel_output();
      video_pkg::vram_addr_t base;
      base = 16'($urandom);
      io_write(video_pkg::SAR, base);
      io_write(video_pkg::MR, 16'd0);
      load_words(base, 0);
      load_palette();
      wait_first_pixel();
      check_scanline(0, "rgb line 0");
   endtask

   // two scanlines per memory line
   task automatic test_row_repeat();
      video_pkg::vram_addr_t base;
      base = 16'($urandom);
      io_write(video_pkg::SAR, base);
      io_write(video_pkg::MR, 16'd1);
      load_words(base, 0);
      load_words(16'(base + `H_VISIBLE), 1);
      wait_first_pixel();
      check_scanline(0, "rgb line 0");
      check_scanline(0, "rgb line 1");
      check_scanline(1, "rgb line 2");
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'he463));
      rst      = 1'b1;
      io_sel   = 1'b0;
      io_wr    = 1'b0;
      io_rd    = 1'b0;
      io_addr  = video_pkg::SAR;
      io_wdata = '0;
      for (int i = 0; i < 4; i++) pal[i] = '0;
      repeat (4) @(negedge pxclk);
      rst = 1'b0;
      test_reg_readback();
      test_vram_access();
      test_sync_timing();
      test_pixel_output();
      test_row_repeat();
      $display("Simulation passed");
      $finish;
   end

endmodule
